// File: rtl/conv_pkg.sv
package conv_pkg;

	// datapath widths
	localparam int DATA_W   = 8;
	// 16 product bits plus 6 bits of growth
	localparam int ACC_W    = 22;
	localparam int NUM_MACS = 4;
	localparam int MAX_TAPS = 16;
	localparam int TAP_W    = 4;
	localparam int LANE_W   = 2;
	localparam int FUNC_W   = 4;

	// function codes, anything else decodes as no function
	localparam logic [FUNC_W-1:0] FN_NONE          = 4'd0;
	localparam logic [FUNC_W-1:0] FN_FILTER_SIZE   = 4'd2;
	localparam logic [FUNC_W-1:0] FN_NUM_FILTERS   = 4'd5;
	localparam logic [FUNC_W-1:0] FN_WEIGHT_LOAD   = 4'd6;
	localparam logic [FUNC_W-1:0] FN_OPERAND_FETCH = 4'd10;

	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [ACC_W-1:0]    acc_t;
	typedef logic [TAP_W-1:0]    tap_t;
	typedef logic [LANE_W-1:0]   lane_t;
	typedef logic [NUM_MACS-1:0] lane_mask_t;

	// one strobe per kept function
	typedef struct packed {
		logic cfg_size;
		logic cfg_filters;
		logic weight_load;
		logic operand_fetch;
	} func_strobes_t;

	// one weight per filter, index is the lane
	typedef data_t [NUM_MACS-1:0] weight_vec_t;

	// operands broadcast to the MAC lanes
	typedef struct packed {
		data_t       neuron;
		weight_vec_t weights;
		lane_mask_t  lane_en;
	} mac_operands_t;

	typedef acc_t [NUM_MACS-1:0] acc_vec_t;

endpackage

// File: rtl/function_decode.sv
module function_decode
	import conv_pkg::*;
(
	input  logic [FUNC_W-1:0] function_sel_i,
	output func_strobes_t     strobes_o
);

	always_comb begin
		strobes_o = '0;
		case (function_sel_i)
			FN_NONE: begin
				strobes_o = '0;
			end
			FN_FILTER_SIZE: begin
				strobes_o.cfg_size = 1'b1;
			end
			FN_NUM_FILTERS: begin
				strobes_o.cfg_filters = 1'b1;
			end
			FN_WEIGHT_LOAD: begin
				strobes_o.weight_load = 1'b1;
			end
			FN_OPERAND_FETCH: begin
				strobes_o.operand_fetch = 1'b1;
			end
			// dropped cache codes land here
			default: begin
				strobes_o = '0;
			end
		endcase
	end

	// downstream blocks assume exclusive strobes
	always_comb begin
		assert ($onehot0(strobes_o))
			else $error("function_decode: more than one strobe active");
	end

endmodule

// File: rtl/layer_config.sv
module layer_config
	import conv_pkg::*;
(
	input  logic          clk,
	input  logic          layer_reset,
	input  func_strobes_t strobes_i,
	input  data_t         data_in_i,
	output tap_t          filter_size_o,
	output lane_mask_t    lane_mask_o
);

	// both values held as count minus one
	tap_t  filter_size_q;
	lane_t num_filters_q;

	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			filter_size_q <= '0;
		end
		else if (strobes_i.cfg_size) begin
			filter_size_q <= data_in_i[TAP_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			num_filters_q <= '0;
		end
		else if (strobes_i.cfg_filters) begin
			num_filters_q <= data_in_i[LANE_W-1:0];
		end
	end

	// thermometer mask, n enables lanes 0..n
	always_comb begin
		for (int i = 0; i < NUM_MACS; i++) begin
			lane_mask_o[i] = (lane_t'(i) <= num_filters_q);
		end
	end

	assign filter_size_o = filter_size_q;

endmodule

// File: rtl/weight_bank.sv
module weight_bank
	import conv_pkg::*;
(
	input  logic          clk,
	input  logic          layer_reset,
	input  func_strobes_t strobes_i,
	input  data_t         data_in_i,
	input  tap_t          filter_size_i,
	input  tap_t          tap_index_i,
	output weight_vec_t   weights_o
);

	// byte within the filter being loaded
	tap_t  byte_cnt_q;
	// filter being loaded
	lane_t filter_idx_q;
	logic  last_byte;

	// per-filter weight storage
	data_t weight_mem [NUM_MACS][MAX_TAPS];

	assign last_byte = (byte_cnt_q == filter_size_i);

	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			byte_cnt_q   <= '0;
			filter_idx_q <= '0;
		end
		else if (strobes_i.weight_load) begin
			if (last_byte) begin
				byte_cnt_q <= '0;
				// wraps back to filter 0 after the last lane
				filter_idx_q <= filter_idx_q + lane_t'(1);
			end
			else begin
				byte_cnt_q <= byte_cnt_q + tap_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (strobes_i.weight_load) begin
			weight_mem[filter_idx_q][byte_cnt_q] <= data_in_i;
		end
	end

	// all filters read at the same tap
	always_comb begin
		for (int i = 0; i < NUM_MACS; i++) begin
			weights_o[i] = weight_mem[i][tap_index_i];
		end
	end

	// filter size must not shrink below the load position
	a_byte_cnt_in_range: assert property (
		@(posedge clk) disable iff (layer_reset)
		strobes_i.weight_load |-> (byte_cnt_q <= filter_size_i)
	) else $error("weight_bank: byte counter beyond filter size");

endmodule

// File: rtl/operand_fetch.sv
module operand_fetch
	import conv_pkg::*;
(
	input  logic          clk,
	input  logic          layer_reset,
	input  func_strobes_t strobes_i,
	input  data_t         data_in_i,
	input  tap_t          filter_size_i,
	input  lane_mask_t    lane_mask_i,
	input  weight_vec_t   weights_i,
	output tap_t          tap_index_o,
	output mac_operands_t operands_o,
	output logic          window_end_o
);

	tap_t        iteration_q;
	logic        last_tap;
	logic        nonzero_neuron;
	logic        last_tap_q;
	logic        window_end_q;
	data_t       neuron_q;
	weight_vec_t weights_q;
	lane_mask_t  lane_en_q;

	assign nonzero_neuron = |data_in_i;
	assign last_tap       = (iteration_q == filter_size_i);
	assign tap_index_o    = iteration_q;

	// tap iteration and end-of-window flag
	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			iteration_q <= '0;
			last_tap_q  <= 1'b0;
		end
		else if (strobes_i.operand_fetch) begin
			last_tap_q <= last_tap;
			if (last_tap) begin
				iteration_q <= '0;
			end
			else begin
				iteration_q <= iteration_q + tap_t'(1);
			end
		end
		else begin
			last_tap_q <= 1'b0;
		end
	end

	// lines the flag up with the last product
	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			window_end_q <= 1'b0;
			lane_en_q    <= '0;
		end
		else begin
			window_end_q <= last_tap_q;
			// zero activation skips every lane
			if (strobes_i.operand_fetch && nonzero_neuron) begin
				lane_en_q <= lane_mask_i;
			end
			else begin
				lane_en_q <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (strobes_i.operand_fetch) begin
			neuron_q  <= data_in_i;
			weights_q <= weights_i;
		end
	end

	assign operands_o   = '{neuron: neuron_q, weights: weights_q, lane_en: lane_en_q};
	assign window_end_o = window_end_q;

endmodule

// File: rtl/mac_array.sv
module mac_array
	import conv_pkg::*;
(
	input  logic          clk,
	input  logic          layer_reset,
	input  mac_operands_t operands_i,
	input  logic          window_end_i,
	output acc_vec_t      result_o,
	output logic          result_valid_o
);

	acc_vec_t acc_q;
	acc_vec_t product;

	// unsigned 8x8 products, zero extended
	always_comb begin
		for (int i = 0; i < NUM_MACS; i++) begin
			product[i] = acc_t'(operands_i.neuron) * acc_t'(operands_i.weights[i]);
		end
	end

	always_ff @(posedge clk or posedge layer_reset) begin
		if (layer_reset) begin
			acc_q          <= '0;
			result_o       <= '0;
			result_valid_o <= 1'b0;
		end
		else begin
			result_valid_o <= window_end_i;
			if (window_end_i) begin
				result_o <= acc_q;
			end
			for (int i = 0; i < NUM_MACS; i++) begin
				if (window_end_i) begin
					// next window may already have its first tap in flight
					acc_q[i] <= operands_i.lane_en[i] ? product[i] : '0;
				end
				else if (operands_i.lane_en[i]) begin
					acc_q[i] <= acc_q[i] + product[i];
				end
			end
		end
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (layer_reset)
		!$isunknown(result_valid_o)
	) else $error("mac_array: result_valid_o unknown");

endmodule

// File: rtl/conv_subunit.sv
module conv_subunit
	import conv_pkg::*;
(
	input  logic              clk,
	input  logic              layer_reset,
	input  logic [FUNC_W-1:0] function_sel_i,
	input  data_t             data_in_i,
	output acc_vec_t          result_o,
	output logic              result_valid_o
);

	func_strobes_t strobes;
	tap_t          filter_size;
	lane_mask_t    lane_mask;
	tap_t          tap_index;
	weight_vec_t   weights;
	mac_operands_t operands;
	logic          window_end;

	function_decode u_function_decode (
		.function_sel_i (function_sel_i),
		.strobes_o      (strobes)
	);

	layer_config u_layer_config (
		.clk           (clk),
		.layer_reset   (layer_reset),
		.strobes_i     (strobes),
		.data_in_i     (data_in_i),
		.filter_size_o (filter_size),
		.lane_mask_o   (lane_mask)
	);

	weight_bank u_weight_bank (
		.clk           (clk),
		.layer_reset   (layer_reset),
		.strobes_i     (strobes),
		.data_in_i     (data_in_i),
		.filter_size_i (filter_size),
		.tap_index_i   (tap_index),
		.weights_o     (weights)
	);

	operand_fetch u_operand_fetch (
		.clk           (clk),
		.layer_reset   (layer_reset),
		.strobes_i     (strobes),
		.data_in_i     (data_in_i),
		.filter_size_i (filter_size),
		.lane_mask_i   (lane_mask),
		.weights_i     (weights),
		.tap_index_o   (tap_index),
		.operands_o    (operands),
		.window_end_o  (window_end)
	);

	mac_array u_mac_array (
		.clk            (clk),
		.layer_reset    (layer_reset),
		.operands_i     (operands),
		.window_end_i   (window_end),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

// File: test/tb_conv_subunit.sv
module tb_conv_subunit
	import conv_pkg::*;
();

	logic              clk;
	logic              layer_reset;
	logic [FUNC_W-1:0] function_sel_i;
	data_t             data_in_i;
	acc_vec_t          result_o;
	logic              result_valid_o;

	// reference model state
	data_t    w_model [NUM_MACS][MAX_TAPS];
	data_t    neurons [MAX_TAPS];
	acc_vec_t exp_mem [16];
	acc_vec_t expected_now;
	tap_t     cfg_fs;
	lane_t    cfg_nf;
	tap_t     load_tap;
	lane_t    load_filt;
	logic     last_tap_mark;
	logic [2:0] mark_pipe;
	int       windows_issued;
	int       result_count = 0;
	int       seed;
	string    test_name;

	conv_subunit u_dut (
		.clk            (clk),
		.layer_reset    (layer_reset),
		.function_sel_i (function_sel_i),
		.data_in_i      (data_in_i),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign expected_now = exp_mem[result_count[3:0]];

	always @(posedge clk) begin
		if (result_valid_o) begin
			result_count <= result_count + 1;
		end
	end

	// last fetch mark delayed to the edge where valid is seen
	always @(posedge clk) begin
		mark_pipe <= {mark_pipe[1:0], last_tap_mark};
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// each result matches the reference sums
	a_result_value: assert property (
		@(posedge clk) disable iff (layer_reset)
		result_valid_o |-> (result_o == expected_now)
	) else fail_run($sformatf("Fail %s: expected %h, actual %h",
		test_name, $sampled(expected_now), $sampled(result_o)));

	// valid pulses two cycles after the last fetch edge
	a_result_timing: assert property (
		@(posedge clk) disable iff (layer_reset)
		result_valid_o == mark_pipe[2]
	) else fail_run($sformatf("Fail %s: expected result_valid_o %0b, actual %0b",
		test_name, $sampled(mark_pipe[2]), $sampled(result_valid_o)));

	// nothing reported before the first window ends
	a_quiet_after_reset: assert property (
		@(posedge clk) disable iff (layer_reset)
		(result_count == 0 && !result_valid_o) |-> (result_o == '0)
	) else fail_run($sformatf("Fail %s: expected %h, actual %h",
		test_name, acc_vec_t'('0), $sampled(result_o)));

	task automatic drive(input logic [FUNC_W-1:0] code, input data_t value, input logic mark);
		@(negedge clk);
		function_sel_i = code;
		data_in_i      = value;
		last_tap_mark  = mark;
	endtask

	task automatic go_idle();
		drive(FN_NONE, '0, 1'b0);
	endtask

	// load position restarts with the DUT
	task automatic apply_reset(input int cycles);
		layer_reset    = 1'b1;
		function_sel_i = FN_NONE;
		data_in_i      = '0;
		last_tap_mark  = 1'b0;
		load_tap       = '0;
		load_filt      = '0;
		repeat (cycles) @(negedge clk);
		layer_reset = 1'b0;
	endtask

	task automatic configure_layer(input tap_t fs, input lane_t nf);
		cfg_fs = fs;
		cfg_nf = nf;
		drive(FN_FILTER_SIZE, data_t'(fs), 1'b0);
		drive(FN_NUM_FILTERS, data_t'(nf), 1'b0);
	endtask

	// filter after filter, tap after tap
	task automatic load_weights(input int count);
		data_t w;
		for (int i = 0; i < count; i++) begin
			w = data_t'($random(seed));
			w_model[load_filt][load_tap] = w;
			if (load_tap == cfg_fs) begin
				load_tap  = '0;
				load_filt = load_filt + lane_t'(1);
			end
			else begin
				load_tap = load_tap + tap_t'(1);
			end
			drive(FN_WEIGHT_LOAD, w, 1'b0);
		end
	endtask

	// zero neurons at taps 1, 4 and 7 when asked
	task automatic run_window(input logic with_zeros);
		acc_vec_t sums;
		acc_t     prod;
		sums = '0;
		for (int t = 0; t <= int'(cfg_fs); t++) begin
			neurons[tap_t'(t)] = data_t'($random(seed)) | 8'h01;
			if (with_zeros && (t % 3 == 1)) begin
				neurons[tap_t'(t)] = '0;
			end
		end
		for (int l = 0; l < NUM_MACS; l++) begin
			for (int t = 0; t <= int'(cfg_fs) && lane_t'(l) <= cfg_nf; t++) begin
				prod = acc_t'(neurons[tap_t'(t)]) * acc_t'(w_model[lane_t'(l)][tap_t'(t)]);
				sums[lane_t'(l)] = sums[lane_t'(l)] + prod;
			end
		end
		exp_mem[windows_issued[3:0]] = sums;
		windows_issued++;
		for (int t = 0; t <= int'(cfg_fs); t++) begin
			drive(FN_OPERAND_FETCH, neurons[tap_t'(t)], t == int'(cfg_fs));
		end
	endtask

	task automatic wait_results(input int target);
		int cycles;
		cycles = 0;
		while (result_count < target && cycles < 40) begin
			@(negedge clk);
			cycles++;
		end
		if (result_count < target) begin
			fail_run($sformatf("timed out in %s waiting for result %0d", test_name, target));
		end
	endtask

	initial begin
		seed           = 71;
		windows_issued = 0;
		test_name      = "reset";
		apply_reset(16);

		test_name = "full_window";
		configure_layer(tap_t'(8), lane_t'(3));
		load_weights(NUM_MACS * 9);
		run_window(1'b0);
		go_idle();
		wait_results(1);

		test_name = "two_lanes";
		configure_layer(tap_t'(8), lane_t'(1));
		run_window(1'b0);
		go_idle();
		wait_results(2);

		test_name = "zero_skip";
		configure_layer(tap_t'(8), lane_t'(3));
		run_window(1'b1);
		go_idle();
		wait_results(3);

		test_name = "back_to_back";
		run_window(1'b0);
		run_window(1'b0);
		go_idle();
		wait_results(5);

		// reset lands while the load strobe is still active
		test_name = "reset_mid_load";
		load_weights(13);
		@(negedge clk);
		apply_reset(2);
		configure_layer(tap_t'(8), lane_t'(3));
		load_weights(NUM_MACS * 9);
		run_window(1'b0);
		go_idle();
		wait_results(6);

		repeat (4) @(negedge clk);
		if (result_count != windows_issued) begin
			fail_run($sformatf("%0d results reported for %0d windows",
				result_count, windows_issued));
		end
		else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: verilog.f
rtl/conv_pkg.sv
rtl/function_decode.sv
rtl/layer_config.sv
rtl/weight_bank.sv
rtl/operand_fetch.sv
rtl/mac_array.sv
rtl/conv_subunit.sv
test/tb_conv_subunit.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_conv_subunit -f verilog.f -o sim_tb; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
